// File: spriteGeomPkg.sv
// sprite geometry
// widths, counts and basic types
`default_nettype none

package spriteGeomPkg;
	// four sprites, each 8x8 pixels
	localparam int numSprites = 4;
	localparam int spriteSize = 8;
	// image ram depth in 16-bit words
	localparam int ramDepth = 256;

	// screen coordinate, used for hPos, vPos, x and y
	typedef logic [9:0] coordT;
	typedef logic [1:0] spriteIdxT;
	// 2-bit color code, 0 is transparent
	typedef logic [1:0] pixelT;
	// one image row, leftmost pixel in bits 15:14
	typedef logic [15:0] rowDataT;
	typedef logic [7:0] ramAddrT;
	// selects an 8-word image, word address is base*8 + row
	typedef logic [4:0] imageBaseT;
endpackage

`default_nettype wire

// File: spriteBusPkg.sv
// sprite host bus and pixel output
// structs and register map
`default_nettype none

package spriteBusPkg;
	import spriteGeomPkg::*;

	// register address is sprite*4 + field
	typedef logic [1:0] regFieldT;
	localparam regFieldT regX = 2'd0;
	localparam regFieldT regY = 2'd1;
	localparam regFieldT regBase = 2'd2;
	localparam regFieldT regEnable = 2'd3;

	// host write strobe, toRam selects image ram vs registers
	typedef struct packed {
		logic        wrEn;
		logic        toRam;
		ramAddrT     addr;
		logic [15:0] data;
	} hostWrT;

	// per-sprite register set
	typedef struct packed {
		coordT     x;
		coordT     y;
		imageBaseT base;
		logic      enable;
	} spriteRegT;

	// composed pixel, one per clock
	typedef struct packed {
		logic      valid;
		logic      hit;
		spriteIdxT idx;
		pixelT     color;
	} spritePixT;
endpackage

`default_nettype wire

// File: spriteRam.sv
// sprite image ram
`timescale 1ns/100ps
`default_nettype none

module spriteRam
	import spriteGeomPkg::*;
(
	input  logic    clka,
	input  logic    rstN,
	// read port, fetch side
	input  ramAddrT adra,
	input  logic    cea,
	output rowDataT doa,
	// write port, host side
	input  ramAddrT adrb,
	input  rowDataT dib,
	input  logic    web
);
	// plain inferred storage
	rowDataT mem [ramDepth];
	// registered read address
	ramAddrT radra;

	// ========================================
	// port a, one cycle read latency
	// ========================================
	always_ff @(posedge clka) begin
		if (!rstN) begin
			radra <= '0;
		end else if (cea) begin
			radra <= adra;
		end
	end

	// data follows the held address
	assign doa = mem[radra];

	// ========================================
	// port b, host writes
	// ========================================
	always_ff @(posedge clka) begin
		if (web) begin
			mem[adrb] <= dib;
		end
	end

	// fetch engine must present a clean address when it reads
	assert property (@(posedge clka) disable iff (!rstN) cea |-> !$isunknown(adra))
		else $error("spriteRam: unknown adra with cea high");

endmodule

`default_nettype wire

// File: spriteRegs.sv
// sprite register file
`timescale 1ns/100ps
`default_nettype none

module spriteRegs
	import spriteGeomPkg::*, spriteBusPkg::*;
(
	input  logic                      clka,
	input  logic                      rstN,
	input  hostWrT                    hostWr,
	output spriteRegT [numSprites-1:0] sprRegs
);
	// decoded register address
	spriteIdxT sel;
	regFieldT  field;
	logic      regWr;

	// addr[3:2] picks the sprite and addr[1:0] the field
	// upper address bits are ignored
	assign sel = hostWr.addr[3:2];
	assign field = hostWr.addr[1:0];
	// strobe for register writes only
	assign regWr = hostWr.wrEn & ~hostWr.toRam;

	// ========================================
	// field write with data truncated per field
	// ========================================
	always_ff @(posedge clka) begin
		if (!rstN) begin
			// all sprites disabled and parked at 0
			sprRegs <= '0;
		end else if (regWr) begin
			case (field)
				regX: begin
					sprRegs[sel].x <= coordT'(hostWr.data);
				end
				regY: begin
					sprRegs[sel].y <= coordT'(hostWr.data);
				end
				regBase: begin
					sprRegs[sel].base <= imageBaseT'(hostWr.data);
				end
				regEnable: begin
					sprRegs[sel].enable <= hostWr.data[0];
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: spriteLineFetch.sv
// line-start row fetch
`timescale 1ns/100ps
`default_nettype none

module spriteLineFetch
	import spriteGeomPkg::*, spriteBusPkg::*;
(
	input  logic                       clka,
	input  logic                       rstN,
	input  logic                       lineStart,
	input  coordT                      vPos,
	input  spriteRegT [numSprites-1:0] sprRegs,
	output ramAddrT                    ramAdr,
	output logic                       ramCe,
	input  rowDataT                    rdData,
	output logic [numSprites-1:0]      rowLoad,
	output rowDataT                    rowData,
	output logic                       fetchBusy
);
	typedef enum logic [1:0] {
		stIdle,
		stIssue,
		stDrain
	} fetchStateT;

	fetchStateT state;
	spriteIdxT  idx;
	// line number held for the whole fetch
	coordT      lineQ;
	coordT      row;
	logic       inRange;
	// load stage, one cycle behind issue
	logic       ldValid;
	spriteIdxT  ldIdx;
	logic       ldInRange;

	// ========================================
	// issue stage
	// ========================================
	// row within the sprite, wraps negative to large values
	assign row = lineQ - sprRegs[idx].y;
	assign inRange = sprRegs[idx].enable && (row < coordT'(spriteSize));
	// base*8 + row
	assign ramAdr = {sprRegs[idx].base, row[2:0]};
	// out-of-range sprites skip the read and load zero
	assign ramCe = (state == stIssue) && inRange;

	always_ff @(posedge clka) begin
		if (!rstN) begin
			state <= stIdle;
			idx <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (lineStart) begin
						state <= stIssue;
						idx <= '0;
					end
				end
				stIssue: begin
					// last sprite issued, one load still pending
					if (idx == spriteIdxT'(numSprites - 1)) begin
						state <= stDrain;
					end
					idx <= idx + 1'b1;
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	// vPos sampled only at an accepted line start
	always_ff @(posedge clka) begin
		if (lineStart && state == stIdle) begin
			lineQ <= vPos;
		end
	end

	// ========================================
	// load stage
	// ========================================
	always_ff @(posedge clka) begin
		if (!rstN) begin
			ldValid <= 1'b0;
		end else begin
			ldValid <= (state == stIssue);
		end
	end

	always_ff @(posedge clka) begin
		ldIdx <= idx;
		ldInRange <= inRange;
	end

	always_comb begin
		rowLoad = '0;
		if (ldValid) begin
			rowLoad[ldIdx] = 1'b1;
		end
	end

	// ram data arrives one cycle after issue
	assign rowData = (ldValid && ldInRange) ? rdData : '0;
	// cycles 1 to 5 after lineStart
	assign fetchBusy = (state != stIdle);

	// raster source must leave the fetch window alone
	assert property (@(posedge clka) disable iff (!rstN) fetchBusy |-> !lineStart)
		else $error("spriteLineFetch: lineStart during fetch");
	assert property (@(posedge clka) disable iff (!rstN) $onehot0(rowLoad))
		else $error("spriteLineFetch: rowLoad not one-hot");

endmodule

`default_nettype wire

// File: spritePixelUnit.sv
// one sprite's row buffer and window
`timescale 1ns/100ps
`default_nettype none

module spritePixelUnit
	import spriteGeomPkg::*;
(
	input  logic    clka,
	input  logic    rstN,
	input  logic    load,
	input  rowDataT rowData,
	input  coordT   x,
	input  coordT   hPos,
	output pixelT   pix
);
	// current line's image row
	rowDataT rowBuf;
	coordT   offset;
	rowDataT shifted;
	logic    inWindow;

	// cleared buffer means a transparent sprite
	always_ff @(posedge clka) begin
		if (!rstN) begin
			rowBuf <= '0;
		end else if (load) begin
			rowBuf <= rowData;
		end
	end

	// ========================================
	// horizontal window test
	// ========================================
	// left of x wraps to a large offset and fails the test
	assign offset = hPos - x;
	assign inWindow = offset < coordT'(spriteSize);

	// bring the selected pixel to the top two bits
	assign shifted = rowBuf << {offset[2:0], 1'b0};
	assign pix = inWindow ? shifted[15:14] : '0;

endmodule

`default_nettype wire

// File: spriteComposer.sv
// sprite units and priority select
`timescale 1ns/100ps
`default_nettype none

module spriteComposer
	import spriteGeomPkg::*, spriteBusPkg::*;
(
	input  logic                       clka,
	input  logic                       rstN,
	input  logic [numSprites-1:0]      rowLoad,
	input  rowDataT                    rowData,
	input  spriteRegT [numSprites-1:0] sprRegs,
	input  logic                       pixelValid,
	input  coordT                      hPos,
	output spritePixT                  spritePix
);
	pixelT     unitPix [numSprites];
	logic      nextHit;
	spriteIdxT nextIdx;
	pixelT     nextColor;

	// one unit per sprite, all share the fetch data bus
	generate
		for (genvar g = 0; g < numSprites; g++) begin : genUnit
			spritePixelUnit unit (
				.clka    (clka),
				.rstN    (rstN),
				.load    (rowLoad[g]),
				.rowData (rowData),
				.x       (sprRegs[g].x),
				.hPos    (hPos),
				.pix     (unitPix[g])
			);
		end
	endgenerate

	// ========================================
	// fixed priority, lowest index wins
	// ========================================
	always_comb begin
		nextHit = 1'b0;
		nextIdx = '0;
		nextColor = '0;
		// scan downward so the lowest opaque sprite lands last
		for (int i = numSprites - 1; i >= 0; i--) begin
			if (unitPix[i] != '0) begin
				nextHit = 1'b1;
				nextIdx = spriteIdxT'(i);
				nextColor = unitPix[i];
			end
		end
	end

	// one cycle pixel latency
	// hit is not gated by pixelValid
	always_ff @(posedge clka) begin
		if (!rstN) begin
			spritePix <= '0;
		end else begin
			spritePix.valid <= pixelValid;
			spritePix.hit <= nextHit;
			spritePix.idx <= nextIdx;
			spritePix.color <= nextColor;
		end
	end

	assert property (@(posedge clka) disable iff (!rstN) spritePix.hit |-> spritePix.color != '0)
		else $error("spriteComposer: hit with transparent color");

endmodule

`default_nettype wire

// File: spriteEngine.sv
// sprite engine top
`timescale 1ns/100ps
`default_nettype none

module spriteEngine
	import spriteGeomPkg::*, spriteBusPkg::*;
(
	input  logic      clka,
	input  logic      rstN,
	// host write port
	input  hostWrT    hostWr,
	// raster timing
	input  logic      lineStart,
	input  coordT     vPos,
	input  logic      pixelValid,
	input  coordT     hPos,
	output spritePixT spritePix,
	output logic      fetchBusy
);
	spriteRegT [numSprites-1:0] sprRegs;
	// fetch to ram
	ramAddrT                    ramAdr;
	logic                       ramCe;
	rowDataT                    rdData;
	// fetch to composer
	logic [numSprites-1:0]      rowLoad;
	rowDataT                    rowData;
	logic                       ramWe;

	// host image writes go straight to ram port b
	assign ramWe = hostWr.wrEn & hostWr.toRam;

	spriteRegs regs0 (
		.clka    (clka),
		.rstN    (rstN),
		.hostWr  (hostWr),
		.sprRegs (sprRegs)
	);

	// ========================================
	// fetch path
	// ========================================
	spriteLineFetch fetch0 (
		.clka      (clka),
		.rstN      (rstN),
		.lineStart (lineStart),
		.vPos      (vPos),
		.sprRegs   (sprRegs),
		.ramAdr    (ramAdr),
		.ramCe     (ramCe),
		.rdData    (rdData),
		.rowLoad   (rowLoad),
		.rowData   (rowData),
		.fetchBusy (fetchBusy)
	);

	spriteRam ram0 (
		.clka (clka),
		.rstN (rstN),
		.adra (ramAdr),
		.cea  (ramCe),
		.doa  (rdData),
		.adrb (hostWr.addr),
		.dib  (hostWr.data),
		.web  (ramWe)
	);

	// pixel path
	spriteComposer comp0 (
		.clka       (clka),
		.rstN       (rstN),
		.rowLoad    (rowLoad),
		.rowData    (rowData),
		.sprRegs    (sprRegs),
		.pixelValid (pixelValid),
		.hPos       (hPos),
		.spritePix  (spritePix)
	);

endmodule

`default_nettype wire

// File: spriteEngine_tb.sv
// sprite engine testbench
`timescale 1ns/100ps
`default_nettype none

module spriteEngine_tb
	import spriteGeomPkg::*, spriteBusPkg::*;
();
	localparam int numRounds = 40;
	localparam int sweepLen = 48;
	localparam int fetchCycles = 8;
	localparam int writeCycles = 16;
	// reset, ram fill, reset sweep and all rounds plus a margin
	localparam int watchdogNs = (16 + ramDepth + sweepLen + 4
		+ numRounds * (writeCycles + fetchCycles + sweepLen + 4)) * 10 + 1000;

	logic      clka;
	logic      rstN;
	hostWrT    hostWr;
	logic      lineStart;
	coordT     vPos;
	logic      pixelValid;
	coordT     hPos;
	spritePixT spritePix;
	logic      fetchBusy;

	// reference model state
	rowDataT   imgModel [ramDepth];
	spriteRegT regModel [numSprites];
	rowDataT   rowModel [numSprites];
	int        checks;
	int        errors;

	spriteEngine dut0 (
		.clka       (clka),
		.rstN       (rstN),
		.hostWr     (hostWr),
		.lineStart  (lineStart),
		.vPos       (vPos),
		.pixelValid (pixelValid),
		.hPos       (hPos),
		.spritePix  (spritePix),
		.fetchBusy  (fetchBusy)
	);

	// 10 ns clock
	always #5 clka = ~clka;

	// ========================================
	// reference model
	// ========================================
	// row word a sprite gets at line start
	function automatic rowDataT fetchRow(input spriteRegT r, input coordT line);
		coordT row;
		int    wordAdr;
		row = line - r.y;
		// image base times 8 plus the row
		wordAdr = int'(r.base) * spriteSize + int'(row[2:0]);
		if (r.enable && row < coordT'(spriteSize)) begin
			return imgModel[ramAddrT'(wordAdr)];
		end
		return '0;
	endfunction

	// pixel of one sprite at hPos h with the leftmost pixel in the top bits
	function automatic pixelT pixelAt(input rowDataT rowWord, input coordT x, input coordT h);
		coordT off;
		int    shiftAmt;
		off = h - x;
		if (off >= coordT'(spriteSize)) begin
			return '0;
		end
		shiftAmt = 2 * (spriteSize - 1 - int'(off));
		return pixelT'(rowWord >> shiftAmt);
	endfunction

	// lowest index opaque pixel wins
	function automatic spritePixT expectPix(input logic valid, input coordT h);
		spritePixT e;
		pixelT     p;
		e = '0;
		e.valid = valid;
		for (int i = 0; i < numSprites; i++) begin
			p = pixelAt(rowModel[i], regModel[i].x, h);
			if (!e.hit && p != '0) begin
				e.hit = 1'b1;
				e.idx = spriteIdxT'(i);
				e.color = p;
			end
		end
		return e;
	endfunction

	// ========================================
	// drive and check helpers
	// ========================================
	// inputs change 1 ns after the rising edge
	task automatic nextCycle();
		@(posedge clka);
		#1;
	endtask

	task automatic writeHost(input logic toRam, input ramAddrT addr, input logic [15:0] data);
		hostWr.wrEn = 1'b1;
		hostWr.toRam = toRam;
		hostWr.addr = addr;
		hostWr.data = data;
		nextCycle();
		hostWr.wrEn = 1'b0;
		// register address is sprite*4 + field and data is cut to the field width
		if (toRam) begin
			imgModel[addr] = data;
		end else begin
			case (regFieldT'(addr[1:0]))
				regX: regModel[addr[3:2]].x = coordT'(data);
				regY: regModel[addr[3:2]].y = coordT'(data);
				regBase: regModel[addr[3:2]].base = imageBaseT'(data);
				default: regModel[addr[3:2]].enable = data[0];
			endcase
		end
	endtask

	task automatic checkPix(input spritePixT exp, input coordT h);
		checks++;
		assert (spritePix.valid == exp.valid) else begin
			$display("FAIL spritePix.valid got %h exp %h hPos %h", spritePix.valid, exp.valid, h);
			errors++;
		end
		// hit only matters on valid pixels
		if (exp.valid) begin
			assert (spritePix.hit == exp.hit) else begin
				$display("FAIL spritePix.hit got %h exp %h hPos %h", spritePix.hit, exp.hit, h);
				errors++;
			end
			assert (spritePix.idx == exp.idx) else begin
				$display("FAIL spritePix.idx got %h exp %h hPos %h", spritePix.idx, exp.idx, h);
				errors++;
			end
			assert (spritePix.color == exp.color) else begin
				$display("FAIL spritePix.color got %h exp %h hPos %h",
					spritePix.color, exp.color, h);
				errors++;
			end
		end
	endtask

	// sweep hPos and check each result one cycle later
	task automatic sweepLine(input coordT firstH);
		spritePixT expQ;
		logic      havePrev;
		havePrev = 1'b0;
		expQ = '0;
		for (int k = 0; k <= sweepLen; k++) begin
			nextCycle();
			if (havePrev) begin
				checkPix(expQ, hPos);
			end
			if (k < sweepLen) begin
				hPos = firstH + coordT'(k);
				// blank pixel now and then
				pixelValid = ($urandom_range(0, 7) != 0);
				expQ = expectPix(pixelValid, hPos);
				havePrev = 1'b1;
			end
		end
		pixelValid = 1'b0;
	endtask

	task automatic startLine(input coordT v);
		int busyCycles;
		assert (!fetchBusy) else begin
			$display("fetchBusy was still high before lineStart");
			errors++;
		end
		lineStart = 1'b1;
		vPos = v;
		for (int i = 0; i < numSprites; i++) begin
			rowModel[i] = fetchRow(regModel[i], v);
		end
		nextCycle();
		lineStart = 1'b0;
		busyCycles = 0;
		// count the fetch window with a bound in case it never ends
		while (fetchBusy && busyCycles < 4 * fetchCycles) begin
			busyCycles++;
			nextCycle();
		end
		checks++;
		assert (!fetchBusy) else begin
			$display("fetchBusy never fell after lineStart");
			errors++;
		end
		assert (busyCycles == 5) else begin
			$display("FAIL fetchBusy cycles got %h exp %h", busyCycles, 5);
			errors++;
		end
	endtask

	// some image words and then register writes with junk in the unused bits
	task automatic randomWrites();
		logic [15:0] data;
		regFieldT    field;
		ramAddrT     addr;
		repeat ($urandom_range(2, 8)) begin
			writeHost(1'b1, ramAddrT'($urandom), 16'($urandom));
		end
		repeat ($urandom_range(2, 8)) begin
			field = regFieldT'($urandom_range(0, 3));
			// positions kept near the small test screen
			case (field)
				regX: data = {6'($urandom), coordT'($urandom_range(0, 40))};
				regY: data = {6'($urandom), coordT'($urandom_range(0, 20))};
				regBase: data = {11'($urandom), 5'($urandom)};
				default: data = {15'($urandom), ($urandom_range(0, 3) != 0)};
			endcase
			addr = {4'($urandom), 2'($urandom_range(0, 3)), field};
			writeHost(1'b0, addr, data);
		end
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		void'($urandom(32'hcbfb));
		clka = 1'b0;
		rstN = 1'b0;
		hostWr = '0;
		lineStart = 1'b0;
		vPos = '0;
		// pixels marked valid during reset so only reset keeps spritePix.valid low
		pixelValid = 1'b1;
		hPos = '0;
		checks = 0;
		errors = 0;
		for (int i = 0; i < numSprites; i++) begin
			regModel[i] = '0;
			rowModel[i] = '0;
		end
		repeat (16) @(posedge clka);
		#1;
		rstN = 1'b1;
		pixelValid = 1'b0;

		// idle after reset with every sprite disabled
		checks++;
		assert (!fetchBusy) else begin
			$display("FAIL fetchBusy got %h exp %h after reset", fetchBusy, 1'b0);
			errors++;
		end
		assert (!spritePix.valid) else begin
			$display("FAIL spritePix.valid got %h exp %h after reset", spritePix.valid, 1'b0);
			errors++;
		end
		sweepLine('0);

		// whole image ram gets known contents
		for (int a = 0; a < ramDepth; a++) begin
			writeHost(1'b1, ramAddrT'(a), 16'($urandom));
		end

		for (int r = 0; r < numRounds; r++) begin
			randomWrites();
			startLine(coordT'($urandom_range(0, 27)));
			sweepLine('0);
		end
		nextCycle();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdogNs);
		$display("watchdog expired at %0t, checks %0d, errors %0d", $time, checks, errors + 1);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: spriteEngine.f
spriteGeomPkg.sv
spriteBusPkg.sv
spriteRam.sv
spriteRegs.sv
spriteLineFetch.sv
spritePixelUnit.sv
spriteComposer.sv
spriteEngine.sv
spriteEngine_tb.sv

// File: run.sh
#!/bin/sh
# build and run the sprite engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module spriteEngine_tb -f spriteEngine.f

out=$(./obj_dir/VspriteEngine_tb)
echo "$out"
echo "$out" | grep -qx "all tests passed"
